//--- hw/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

	////////////////////////////////////////
	// horizontal raster, in pixels
	localparam int h_active = 640;
	localparam int h_front  = 16;
	localparam int h_sync   = 96;
	localparam int h_back   = 48;
	localparam int h_total  = h_active + h_front + h_sync + h_back;

	////////////////////////////////////////
	// vertical raster, in lines
	localparam int v_active = 480;
	localparam int v_front  = 10;
	localparam int v_sync   = 2;
	localparam int v_back   = 33;
	localparam int v_total  = v_active + v_front + v_sync + v_back;

	// sync pulse windows, end exclusive
	localparam int h_sync_start = h_active + h_front;
	localparam int h_sync_end   = h_sync_start + h_sync;
	localparam int v_sync_start = v_active + v_front;
	localparam int v_sync_end   = v_sync_start + v_sync;

	// wide enough for 0..799
	typedef logic [9:0] coord_t;

endpackage

`default_nettype wire

//--- hw/game_screen_pkg.sv
`default_nettype none

package game_screen_pkg;

	typedef enum logic [1:0] {
		screen_title   = 2'd0,
		screen_players = 2'd1,
		screen_leaders = 2'd2,
		screen_board   = 2'd3
	} screen_e;

	// blue in the top byte, red in the bottom
	typedef logic [23:0] rgb_t;

	localparam rgb_t col_back   = 24'h150088;
	localparam rgb_t col_title  = 24'h120d20;
	localparam rgb_t col_button = 24'h2fb0e8;
	localparam rgb_t col_header = 24'h7a2c1e;
	localparam rgb_t col_rank   = 24'hd8d8d8;
	localparam rgb_t col_row    = 24'h3a6a14;
	localparam rgb_t col_arrow  = 24'h521494;
	localparam rgb_t col_die    = 24'hf0f0f0;
	localparam rgb_t col_pip    = 24'h101010;
	localparam rgb_t col_empty  = 24'h404040;

	////////////////////////////////////////
	// screen regions: left, right, top, bottom (right and bottom exclusive)
	localparam int title_l  = 63,  title_r  = 559, title_t  = 81,  title_b  = 186;
	localparam int start_l  = 228, start_r  = 400, start_t  = 204, start_b  = 373;
	localparam int player_l = 230, player_r = 405, player_t = 205, player_b = 464;
	localparam int header_l = 112, header_r = 524, header_t = 58,  header_b = 149;
	localparam int rank_l   = 122, rank_r   = 185, rank_t   = 198, rank_b   = 401;
	localparam int row1_l   = 18,  row1_r   = 617, row1_t   = 18,  row1_b   = 97;
	localparam int row2_l   = 31,  row2_r   = 615, row2_t   = 124, row2_b   = 227;
	localparam int row3_l   = 195, row3_r   = 437, row3_t   = 257, row3_b   = 320;

	// arrow marker, one slot per scoring box
	localparam int num_arrow = 13;
	localparam int arrow_w   = 25;
	localparam int arrow_h   = 19;
	localparam int arrow_left [num_arrow] = '{52, 157, 256, 356, 456, 559,
		65, 163, 257, 349, 448, 545, 301};
	localparam int arrow_top [num_arrow] = '{102, 102, 102, 102, 102, 102,
		231, 231, 231, 231, 231, 231, 322};

	// die cells along the bottom of the board
	localparam int num_dice  = 5;
	localparam int die_top   = 344;
	localparam int die_size  = 120;
	localparam int die_left0 = 8;
	localparam int die_pitch = 126;
	localparam int pip_lo    = 20;
	localparam int pip_mid   = 60;
	localparam int pip_hi    = 100;
	localparam int pip_half  = 10;

	// 0 and 7 mark an empty slot
	typedef logic [2:0] die_t;
	typedef logic [3*num_dice-1:0] dice_bus_t;
	// 13..15 hide the marker
	typedef logic [3:0] arrow_t;

	typedef logic [1:0] reg_addr_t;
	localparam reg_addr_t reg_screen = 2'd0;
	localparam reg_addr_t reg_dice   = 2'd1;
	localparam reg_addr_t reg_arrow  = 2'd2;

endpackage

`default_nettype wire

//--- hw/game_regs.sv
`default_nettype none

module game_regs (
	input  wire                         VGA_CLK_n,
	input  wire                         iRST_n,
	input  wire                         wb_cyc,
	input  wire                         wb_stb,
	input  wire                         wb_we,
	input  wire game_screen_pkg::reg_addr_t wb_adr,
	input  wire [31:0]                  wb_dat_w,
	output logic [31:0]                 wb_dat_r,
	output logic                        wb_ack,
	output game_screen_pkg::screen_e    screen,
	output game_screen_pkg::dice_bus_t  dice,
	output game_screen_pkg::arrow_t     arrow_pos
);
	import game_screen_pkg::*;

	logic req;

	// new request only while ack is low, so a held request sees every other cycle
	assign req = wb_cyc && wb_stb && !wb_ack;

	////////////////////////////////////////
	// ack and register writes
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			wb_ack    <= 1'b0;
			screen    <= screen_title;
			dice      <= '0;
			arrow_pos <= '0;
		end else begin
			wb_ack <= req;
			if (req && wb_we) begin
				case (wb_adr)
					reg_screen: screen <= screen_e'(wb_dat_w[1:0]);
					reg_dice:   dice <= wb_dat_w[3*num_dice-1:0];
					reg_arrow:  arrow_pos <= wb_dat_w[3:0];
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// read back, held by the master until ack
	always_comb begin
		wb_dat_r = '0;
		case (wb_adr)
			reg_screen: wb_dat_r[1:0] = screen;
			reg_dice:   wb_dat_r[3*num_dice-1:0] = dice;
			reg_arrow:  wb_dat_r[3:0] = arrow_pos;
			// unmapped word reads zero
			default:    wb_dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/vga_timing.sv
`default_nettype none

module vga_timing (
	input  wire                   VGA_CLK_n,
	input  wire                   iRST_n,
	output vga_timing_pkg::coord_t x,
	output vga_timing_pkg::coord_t y,
	output logic                  active,
	output logic                  hs_c,
	output logic                  vs_c,
	output logic                  blank_c
);
	import vga_timing_pkg::*;

	coord_t h_cnt;
	coord_t v_cnt;
	logic   h_last;
	logic   v_last;

	assign h_last = (h_cnt == coord_t'(h_total - 1));
	assign v_last = (v_cnt == coord_t'(v_total - 1));

	////////////////////////////////////////
	// raster counters, 800 x 525
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				// next line, or back to the top
				if (v_last)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// decode of the current count
	assign x       = h_cnt;
	assign y       = v_cnt;
	assign active  = (h_cnt < coord_t'(h_active)) && (v_cnt < coord_t'(v_active));
	assign blank_c = !active;

	// both syncs negative
	assign hs_c = !((h_cnt >= coord_t'(h_sync_start)) && (h_cnt < coord_t'(h_sync_end)));
	assign vs_c = !((v_cnt >= coord_t'(v_sync_start)) && (v_cnt < coord_t'(v_sync_end)));

endmodule

`default_nettype wire

//--- hw/die_pips.sv
`default_nettype none

module die_pips (
	input  wire vga_timing_pkg::coord_t     x,
	input  wire vga_timing_pkg::coord_t     y,
	input  wire game_screen_pkg::dice_bus_t dice,
	output logic                            die_hit,
	output logic                            die_empty,
	output logic                            pip_hit
);
	import vga_timing_pkg::*;
	import game_screen_pkg::*;

	// offset inside the 20 pixel square around a slot
	function automatic logic near(coord_t off, int slot);
		return (off >= coord_t'(slot - pip_half)) && (off < coord_t'(slot + pip_half));
	endfunction

	coord_t ox;
	coord_t oy;
	die_t   val;
	logic   col_l, col_c, col_r;
	logic   row_t, row_m, row_b;
	logic   diag, anti, centre, sides;

	////////////////////////////////////////
	// find the cell under the pixel
	always_comb begin
		coord_t left;
		die_hit = 1'b0;
		val     = '0;
		ox      = '0;
		oy      = coord_t'(y - coord_t'(die_top));
		for (int i = 0; i < num_dice; i++) begin
			left = coord_t'(die_left0 + i * die_pitch);
			if ((x >= left) && (x < left + coord_t'(die_size)) &&
				(y >= coord_t'(die_top)) && (y < coord_t'(die_top + die_size))) begin
				die_hit = 1'b1;
				val     = dice[3*i +: 3];
				ox      = x - left;
			end
		end
	end

	assign col_l = near(ox, pip_lo);
	assign col_c = near(ox, pip_mid);
	assign col_r = near(ox, pip_hi);
	assign row_t = near(oy, pip_lo);
	assign row_m = near(oy, pip_mid);
	assign row_b = near(oy, pip_hi);

	// top left with bottom right, then the other pair of corners
	assign diag   = (col_l && row_t) || (col_r && row_b);
	assign anti   = (col_r && row_t) || (col_l && row_b);
	assign centre = col_c && row_m;
	assign sides  = (col_l || col_r) && row_m;

	assign die_empty = die_hit && ((val == 3'd0) || (val == 3'd7));

	always_comb begin
		case (val)
			3'd1:    pip_hit = centre;
			3'd2:    pip_hit = diag;
			3'd3:    pip_hit = diag || centre;
			3'd4:    pip_hit = diag || anti;
			3'd5:    pip_hit = diag || anti || centre;
			3'd6:    pip_hit = diag || anti || sides;
			default: pip_hit = 1'b0;
		endcase
		pip_hit = pip_hit && die_hit;
	end

endmodule

`default_nettype wire

//--- hw/screen_painter.sv
`default_nettype none

module screen_painter (
	input  wire                          VGA_CLK_n,
	input  wire                          iRST_n,
	input  wire game_screen_pkg::screen_e screen,
	input  wire game_screen_pkg::arrow_t  arrow_pos,
	input  wire vga_timing_pkg::coord_t   x,
	input  wire vga_timing_pkg::coord_t   y,
	input  wire                          active,
	input  wire                          hs_c,
	input  wire                          vs_c,
	input  wire                          blank_c,
	input  wire                          die_hit,
	input  wire                          die_empty,
	input  wire                          pip_hit,
	output logic                         hs,
	output logic                         vs,
	output logic                         blank_n,
	output logic [7:0]                   r_data,
	output logic [7:0]                   g_data,
	output logic [7:0]                   b_data
);
	import vga_timing_pkg::*;
	import game_screen_pkg::*;

	// right and bottom edges exclusive
	function automatic logic in_box(coord_t px, coord_t py, int l, int r, int t, int b);
		return (px >= coord_t'(l)) && (px < coord_t'(r)) &&
			(py >= coord_t'(t)) && (py < coord_t'(b));
	endfunction

	rgb_t colour;
	rgb_t colour_q;
	logic arrow_hit;
	logic row_hit;

	////////////////////////////////////////
	// board overlays
	always_comb begin
		arrow_hit = 1'b0;
		for (int i = 0; i < num_arrow; i++) begin
			if ((arrow_pos == arrow_t'(i)) && in_box(x, y, arrow_left[i],
				arrow_left[i] + arrow_w, arrow_top[i], arrow_top[i] + arrow_h))
				arrow_hit = 1'b1;
		end
	end

	assign row_hit = in_box(x, y, row1_l, row1_r, row1_t, row1_b) ||
		in_box(x, y, row2_l, row2_r, row2_t, row2_b) ||
		in_box(x, y, row3_l, row3_r, row3_t, row3_b);

	////////////////////////////////////////
	// colour per screen, first match wins
	always_comb begin
		colour = col_back;
		case (screen)
			screen_title: begin
				if (in_box(x, y, title_l, title_r, title_t, title_b))
					colour = col_title;
				else if (in_box(x, y, start_l, start_r, start_t, start_b))
					colour = col_button;
			end
			screen_players: begin
				if (in_box(x, y, title_l, title_r, title_t, title_b))
					colour = col_title;
				else if (in_box(x, y, player_l, player_r, player_t, player_b))
					colour = col_button;
			end
			screen_leaders: begin
				if (in_box(x, y, header_l, header_r, header_t, header_b))
					colour = col_header;
				else if (in_box(x, y, rank_l, rank_r, rank_t, rank_b))
					colour = col_rank;
			end
			default: begin
				if (arrow_hit)
					colour = col_arrow;
				else if (row_hit)
					colour = col_row;
				else if (pip_hit)
					colour = col_pip;
				else if (die_empty)
					colour = col_empty;
				else if (die_hit)
					colour = col_die;
			end
		endcase
		// black outside the visible area
		if (!active)
			colour = '0;
	end

	// colour and syncs leave on the same edge
	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			hs       <= 1'b1;
			vs       <= 1'b1;
			blank_n  <= 1'b0;
			colour_q <= '0;
		end else begin
			hs       <= hs_c;
			vs       <= vs_c;
			blank_n  <= !blank_c;
			colour_q <= colour;
		end
	end

	assign b_data = colour_q[23:16];
	assign g_data = colour_q[15:8];
	assign r_data = colour_q[7:0];

endmodule

`default_nettype wire

//--- hw/game_display_top.sv
`default_nettype none

module game_display_top (
	input  wire                             VGA_CLK_n,
	input  wire                             iRST_n,
	input  wire                             wb_cyc,
	input  wire                             wb_stb,
	input  wire                             wb_we,
	input  wire game_screen_pkg::reg_addr_t wb_adr,
	input  wire [31:0]                      wb_dat_w,
	output logic [31:0]                     wb_dat_r,
	output logic                            wb_ack,
	output logic                            hs,
	output logic                            vs,
	output logic                            blank_n,
	output logic [7:0]                      r_data,
	output logic [7:0]                      g_data,
	output logic [7:0]                      b_data
);
	import vga_timing_pkg::*;
	import game_screen_pkg::*;

	screen_e   screen;
	dice_bus_t dice;
	arrow_t    arrow_pos;
	coord_t    x;
	coord_t    y;
	logic      active, hs_c, vs_c, blank_c;
	logic      die_hit, die_empty, pip_hit;

	////////////////////////////////////////
	// processor side
	game_regs i_regs (.VGA_CLK_n, .iRST_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
		.wb_dat_w, .wb_dat_r, .wb_ack, .screen, .dice, .arrow_pos);

	////////////////////////////////////////
	// raster and pixel path
	vga_timing i_timing (.VGA_CLK_n, .iRST_n, .x, .y, .active, .hs_c, .vs_c, .blank_c);

	die_pips i_dice (.x, .y, .dice, .die_hit, .die_empty, .pip_hit);

	screen_painter i_painter (.VGA_CLK_n, .iRST_n, .screen, .arrow_pos, .x, .y,
		.active, .hs_c, .vs_c, .blank_c, .die_hit, .die_empty, .pip_hit,
		.hs, .vs, .blank_n, .r_data, .g_data, .b_data);

endmodule

`default_nettype wire

//--- dv/tb_game_display.sv
`default_nettype none

module tb_game_display;
	import vga_timing_pkg::*;
	import game_screen_pkg::*;

	localparam int frame_cycles = h_total * v_total;
	localparam int board_frames = 4;
	// frames for the register tests, the three static screens, the board and a margin
	localparam int cycle_limit = (board_frames + 8) * frame_cycles;

	logic        VGA_CLK_n = 1'b0;
	logic        iRST_n;
	logic        wb_cyc, wb_stb, wb_we;
	logic [1:0]  wb_adr;
	logic [31:0] wb_dat_w;
	wire  [31:0] wb_dat_r;
	wire         wb_ack, hs, vs, blank_n;
	wire  [7:0]  r_data, g_data, b_data;

	int   error_count = 0;
	int   cycles = 0;
	int   sh_screen = 0, sh_dice = 0, sh_arrow = 0;
	int   x_cnt = 0, line_cnt = 0;
	int   hs_low = 0, hs_per = 0, vs_low = 0, vs_per = 0;
	logic hs_q = 1'b1, vs_q = 1'b1, blank_q = 1'b0;
	logic hs_seen = 1'b0, vs_seen = 1'b0;
	rgb_t exp_col;
	logic [31:0] rd;

	game_display_top i_dut (.VGA_CLK_n, .iRST_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
		.wb_dat_w, .wb_dat_r, .wb_ack, .hs, .vs, .blank_n, .r_data, .g_data, .b_data);

	always #20 VGA_CLK_n = ~VGA_CLK_n;

	task automatic report_error(string msg);
		error_count++;
		$display("[ERROR] %0t %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	////////////////////////////////////////
	// reference model of the picture
	function automatic logic inside_rect(int px, int py, int l, int r, int t, int b);
		return px >= l && px < r && py >= t && py < b;
	endfunction

	function automatic logic on_pip(int ox, int oy, int cx, int cy);
		return inside_rect(ox, oy, cx - pip_half, cx + pip_half, cy - pip_half, cy + pip_half);
	endfunction

	function automatic logic pip_pattern(int v, int ox, int oy);
		logic main_pair, other_pair, mid, sides;
		main_pair  = on_pip(ox, oy, 20, 20) || on_pip(ox, oy, 100, 100);
		other_pair = on_pip(ox, oy, 100, 20) || on_pip(ox, oy, 20, 100);
		mid        = on_pip(ox, oy, 60, 60);
		sides      = on_pip(ox, oy, 20, 60) || on_pip(ox, oy, 100, 60);
		case (v)
			1: return mid;
			2: return main_pair;
			3: return main_pair || mid;
			4: return main_pair || other_pair;
			5: return main_pair || other_pair || mid;
			6: return main_pair || other_pair || sides;
			default: return 1'b0;
		endcase
	endfunction

	function automatic rgb_t expected_colour(int scr, int dv, int arr, int px, int py);
		rgb_t c;
		int   left, v;
		c = col_back;
		if (scr == 0) begin
			if (inside_rect(px, py, 63, 559, 81, 186)) c = col_title;
			else if (inside_rect(px, py, 228, 400, 204, 373)) c = col_button;
		end else if (scr == 1) begin
			if (inside_rect(px, py, 63, 559, 81, 186)) c = col_title;
			else if (inside_rect(px, py, 230, 405, 205, 464)) c = col_button;
		end else if (scr == 2) begin
			if (inside_rect(px, py, 112, 524, 58, 149)) c = col_header;
			else if (inside_rect(px, py, 122, 185, 198, 401)) c = col_rank;
		end else if (arr < 13 && inside_rect(px, py, arrow_left[arr],
			arrow_left[arr] + 25, arrow_top[arr], arrow_top[arr] + 19)) begin
			c = col_arrow;
		end else if (inside_rect(px, py, 18, 617, 18, 97) ||
			inside_rect(px, py, 31, 615, 124, 227) ||
			inside_rect(px, py, 195, 437, 257, 320)) begin
			c = col_row;
		end else begin
			for (int i = 0; i < 5; i++) begin
				left = 8 + 126 * i;
				if (inside_rect(px, py, left, left + 120, 344, 464)) begin
					v = (dv >> (3 * i)) & 7;
					if (v == 0 || v == 7) c = col_empty;
					else if (pip_pattern(v, px - left, py - 344)) c = col_pip;
					else c = col_die;
				end
			end
		end
		return c;
	endfunction

	assign exp_col = expected_colour(sh_screen, sh_dice, sh_arrow, x_cnt, line_cnt);

	////////////////////////////////////////
	// scoreboard counters stepped once per pixel
	always @(posedge VGA_CLK_n) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
		hs_q    <= hs;
		vs_q    <= vs;
		blank_q <= blank_n;
		x_cnt   <= blank_n ? x_cnt + 1 : 0;
		if (!vs) line_cnt <= 0;
		else if (blank_q && !blank_n) line_cnt <= line_cnt + 1;
		hs_low <= hs ? 0 : hs_low + 1;
		vs_low <= vs ? 0 : vs_low + 1;
		if (!hs && hs_q) begin
			hs_seen <= 1'b1;
			hs_per  <= 1;
		end else hs_per <= hs_per + 1;
		if (!vs && vs_q) begin
			vs_seen <= 1'b1;
			vs_per  <= 1;
		end else vs_per <= vs_per + 1;
	end

	////////////////////////////////////////
	// checks
	reset_state: assert property (@(posedge VGA_CLK_n) !iRST_n |->
		(hs && vs && !blank_n && {b_data, g_data, r_data} == 24'h0 && !wb_ack))
		else report_error("outputs not in reset state");
	hs_width: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(hs && !hs_q) |-> hs_low == h_sync) else report_error("hs low width wrong");
	hs_period: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(!hs && hs_q && hs_seen) |-> hs_per == 800) else report_error("hs period wrong");
	vs_width: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(vs && !vs_q) |-> vs_low == 1600) else report_error("vs low width wrong");
	vs_period: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(!vs && vs_q && vs_seen) |-> vs_per == 420000) else report_error("vs period wrong");
	active_len: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		(!blank_n && blank_q) |-> x_cnt == 640) else report_error("active line length wrong");
	pixel_ok: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		blank_n |-> {b_data, g_data, r_data} == exp_col)
		else report_error($sformatf("pixel (%0d,%0d) is %h, expected %h", x_cnt, line_cnt,
			{b_data, g_data, r_data}, exp_col));
	blank_black: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		!blank_n |-> {b_data, g_data, r_data} == 24'h0) else report_error("colour in blanking");
	ack_single: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		wb_ack |=> !wb_ack) else report_error("ack held for more than one cycle");

	////////////////////////////////////////
	// Wishbone master
	task automatic wb_access(logic we, logic [1:0] adr, logic [31:0] wdata,
		output logic [31:0] rdata);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		n = 0;
		do begin
			@(negedge VGA_CLK_n);
			n++;
		end while (!wb_ack && n < 8);
		if (!wb_ack)
			report_error("no Wishbone ack within 8 cycles");
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		if (we && adr == reg_screen) sh_screen = wdata & 3;
		if (we && adr == reg_dice)   sh_dice = wdata & 32'h7fff;
		if (we && adr == reg_arrow)  sh_arrow = wdata & 15;
		@(negedge VGA_CLK_n);
	endtask

	// a read request kept up across its acks, counting the acks seen
	task automatic hold_request(int n_cycles, output int acks);
		acks   = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = reg_screen;
		repeat (n_cycles) begin
			@(negedge VGA_CLK_n);
			if (wb_ack)
				acks++;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge VGA_CLK_n);
	endtask

	task automatic read_expect(logic [1:0] adr, logic [31:0] exp);
		logic [31:0] got;
		wb_access(1'b0, adr, 32'h0, got);
		assert (got == exp) else report_error($sformatf("read of %0d gave %h, expected %h",
			adr, got, exp));
	endtask

	task automatic wait_vsync;
		@(negedge vs);
		@(negedge VGA_CLK_n);
	endtask

	initial begin
		logic [31:0] dv;
		int          acks;
		void'($urandom(32'h3486));
		iRST_n   = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 2'd0;
		wb_dat_w = 32'h0;
		#10 iRST_n = 1'b0;
		repeat (10) @(negedge VGA_CLK_n);
		iRST_n = 1'b1;

		// register tests inside the first vertical blank
		wait_vsync();
		for (int a = 0; a < 4; a++) read_expect(a[1:0], 32'h0);
		// one ack per two cycles while the master keeps asking
		hold_request(8, acks);
		assert (acks == 4) else report_error($sformatf("held request got %0d acks, expected 4",
			acks));
		for (int a = 0; a < 4; a++) wb_access(1'b1, a[1:0], 32'hffff_ffff, rd);
		read_expect(reg_screen, 32'h3);
		read_expect(reg_dice, 32'h7fff);
		read_expect(reg_arrow, 32'hf);
		read_expect(2'd3, 32'h0);
		wb_access(1'b1, reg_dice, 32'h0, rd);
		wb_access(1'b1, reg_arrow, 32'h0, rd);

		for (int s = 0; s < 3; s++) begin
			wait_vsync();
			wb_access(1'b1, reg_screen, s, rd);
		end

		for (int f = 0; f < board_frames; f++) begin
			wait_vsync();
			wb_access(1'b1, reg_screen, 32'd3, rd);
			dv = 0;
			for (int i = 0; i < 5; i++) dv |= $urandom_range(7, 0) << (3 * i);
			// every face and both empty codes appear at least once
			if (f == 0) dv = {17'h0, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1};
			if (f == 1) dv = {dv[31:9], 3'd7, 3'd0, 3'd6};
			wb_access(1'b1, reg_dice, dv, rd);
			wb_access(1'b1, reg_arrow,
				(f == board_frames - 1) ? $urandom_range(15, 13) : $urandom_range(12, 0), rd);
			read_expect(reg_dice, dv & 32'h7fff);
		end
		wait_vsync();

		if (error_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "errors seen");
		end
	end

endmodule

`default_nettype wire

//--- sim.f
hw/vga_timing_pkg.sv
hw/game_screen_pkg.sv
hw/game_regs.sv
hw/vga_timing.sv
hw/die_pips.sv
hw/screen_painter.sv
hw/game_display_top.sv
dv/tb_game_display.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_game_display \
		-Mdir obj_dir -f sim.f

run: compile
	@out=$$(./obj_dir/Vtb_game_display); echo "$$out"; \
		echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
